// ==== source/tcb_pkg.sv ====
/* shared bus widths, response delay, address map and register layout
   for the TCB subsystem; modules import it inside their bodies */

package tcb_pkg;

  ////////////////////////////////////////
  // bus widths and response delay
  ////////////////////////////////////////

  localparam int unsigned ABW = 16;
  localparam int unsigned DBW = 32;
  localparam int unsigned BEW = DBW / 8;
  // cycles from transfer to response
  localparam int unsigned DLY = 2;

  typedef logic [ABW-1:0] adr_t;
  typedef logic [DBW-1:0] dat_t;
  typedef logic [BEW-1:0] ben_t;

  // decoded target of a request
  typedef enum logic [1:0] {
    SEL_MEM,
    SEL_REG,
    SEL_NONE
  } sel_t;

  ////////////////////////////////////////
  // address map
  ////////////////////////////////////////

  localparam int unsigned MEM_WORDS = 256;
  // word index width inside the memory window
  localparam int unsigned MEM_AW = $clog2(MEM_WORDS);
  localparam adr_t        MEM_BASE = 16'h0000;

  localparam adr_t        REG_BASE = 16'h1000;
  localparam int unsigned REG_BYTES = 16;
  // word offset width inside the register window
  localparam int unsigned REG_OFS_W = $clog2(REG_BYTES / 4);

  // register word offsets
  localparam logic [REG_OFS_W-1:0] REG_SCRATCH = REG_OFS_W'(0);
  localparam logic [REG_OFS_W-1:0] REG_ID = REG_OFS_W'(1);
  localparam logic [REG_OFS_W-1:0] REG_WCNT = REG_OFS_W'(2);

  localparam dat_t REG_ID_VALUE = 32'h7cb5_0102;

endpackage

// ==== source/tcb_dly.sv ====
/* fixed delay line: a payload and its valid bit leave DLY cycles after
   they enter; one instance per response path or select */

`timescale 1ns/1ns

module tcb_dly #(
  parameter type payload_t = tcb_pkg::dat_t
) (
  input  logic     tcb,
  input  logic     arst_n,
  input  logic     in_vld,
  input  payload_t in_dat,
  output logic     out_vld,
  output payload_t out_dat
);

  import tcb_pkg::*;

  // stage 0 takes the input, last stage drives the output
  logic     vld_q [DLY];
  payload_t dat_q [DLY];

  ////////////////////////////////////////
  // valid chain
  ////////////////////////////////////////

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DLY; i++) begin
        vld_q[i] <= 1'b0;
      end
    end else begin
      vld_q[0] <= in_vld;
      for (int i = 1; i < DLY; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  ////////////////////////////////////////
  // payload chain
  ////////////////////////////////////////

  // a stage only loads behind a valid bit, idle cycles hold
  always_ff @(posedge tcb) begin
    if (in_vld) begin
      dat_q[0] <= in_dat;
    end
    for (int i = 1; i < DLY; i++) begin
      if (vld_q[i-1]) begin
        dat_q[i] <= dat_q[i-1];
      end
    end
  end

  assign out_vld = vld_q[DLY-1];
  assign out_dat = dat_q[DLY-1];

endmodule

// ==== source/tcb_mem.sv ====
/* word memory subordinate with byte enabled writes; the read word,
   or zero for a write, comes back DLY cycles after the transfer */

`timescale 1ns/1ns

module tcb_mem (
  input  logic          tcb,
  input  logic          arst_n,
  // request
  input  logic          vld,
  input  logic          wen,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::dat_t wdt,
  // response
  output logic          rsp,
  output tcb_pkg::dat_t rdt,
  output logic          err
);

  import tcb_pkg::*;

  dat_t              mem [MEM_WORDS];
  logic [MEM_AW-1:0] word;
  dat_t              rd_dat;

  // word index inside the window, byte bits dropped
  assign word = adr[2 +: MEM_AW];

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (vld && wen) begin
      for (int b = 0; b < BEW; b++) begin
        if (ben[b]) begin
          mem[word][8*b +: 8] <= wdt[8*b +: 8];
        end
      end
    end
  end

  // a write answers zero
  assign rd_dat = wen ? '0 : mem[word];

  ////////////////////////////////////////
  // response pipeline
  ////////////////////////////////////////

  tcb_dly #(
    .payload_t (dat_t)
  ) u_dly_rdt (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .in_vld  (vld),
    .in_dat  (rd_dat),
    .out_vld (rsp),
    .out_dat (rdt)
  );

  assign err = 1'b0;

endmodule

// ==== source/tcb_regs.sv ====
/* register block subordinate: scratch register, identifier and a count
   of scratch writes; bad offsets and read-only writes answer err */

`timescale 1ns/1ns

module tcb_regs (
  input  logic          tcb,
  input  logic          arst_n,
  // request
  input  logic          vld,
  input  logic          wen,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::dat_t wdt,
  // response
  output logic          rsp,
  output tcb_pkg::dat_t rdt,
  output logic          err
);

  import tcb_pkg::*;

  logic [REG_OFS_W-1:0] ofs;
  dat_t                 scratch;
  dat_t                 wcnt;
  logic                 scr_wr;
  dat_t                 rd_dat;
  logic                 rd_err;

  // word offset inside the window, byte bits dropped
  assign ofs = adr[2 +: REG_OFS_W];

  ////////////////////////////////////////
  // access decode
  ////////////////////////////////////////

  always_comb begin
    rd_dat = '0;
    rd_err = 1'b0;
    scr_wr = 1'b0;
    case (ofs)
      REG_SCRATCH: begin
        if (wen) begin
          scr_wr = vld;
        end else begin
          rd_dat = scratch;
        end
      end
      // read-only, a write is refused
      REG_ID: begin
        if (wen) begin
          rd_err = 1'b1;
        end else begin
          rd_dat = REG_ID_VALUE;
        end
      end
      REG_WCNT: begin
        if (wen) begin
          rd_err = 1'b1;
        end else begin
          rd_dat = wcnt;
        end
      end
      // unused offset
      default: begin
        rd_err = 1'b1;
      end
    endcase
  end

  ////////////////////////////////////////
  // state
  ////////////////////////////////////////

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      scratch <= '0;
      wcnt <= '0;
    end else if (scr_wr) begin
      for (int b = 0; b < BEW; b++) begin
        if (ben[b]) begin
          scratch[8*b +: 8] <= wdt[8*b +: 8];
        end
      end
      wcnt <= wcnt + dat_t'(1);
    end
  end

  // response pipelines, both valid chains run in lockstep
  tcb_dly #(
    .payload_t (dat_t)
  ) u_dly_rdt (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .in_vld  (vld),
    .in_dat  (rd_dat),
    .out_vld (rsp),
    .out_dat (rdt)
  );

  tcb_dly #(
    .payload_t (logic)
  ) u_dly_err (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .in_vld  (vld),
    .in_dat  (rd_err),
    .out_vld (),
    .out_dat (err)
  );

endmodule

// ==== source/tcb_dec.sv ====
/* address decoder: gates the request strobe to the addressed target and
   forwards that target's response DLY cycles later */

`timescale 1ns/1ns

module tcb_dec (
  input  logic          tcb,
  input  logic          arst_n,
  // manager request
  input  logic          vld,
  input  tcb_pkg::adr_t adr,
  // target strobes
  output logic          mem_vld,
  output logic          reg_vld,
  // target responses
  input  tcb_pkg::dat_t mem_rdt,
  input  logic          mem_err,
  input  tcb_pkg::dat_t reg_rdt,
  input  logic          reg_err,
  // manager response
  output logic          rsp,
  output tcb_pkg::dat_t rdt,
  output logic          err
);

  import tcb_pkg::*;

  sel_t sel;
  sel_t dly_sel;

  ////////////////////////////////////////
  // request decode
  ////////////////////////////////////////

  // window match on the bits above each window size
  always_comb begin
    if (adr[ABW-1:MEM_AW+2] == MEM_BASE[ABW-1:MEM_AW+2]) begin
      sel = SEL_MEM;
    end else if (adr[ABW-1:REG_OFS_W+2] == REG_BASE[ABW-1:REG_OFS_W+2]) begin
      sel = SEL_REG;
    end else begin
      sel = SEL_NONE;
    end
  end

  assign mem_vld = vld && (sel == SEL_MEM);
  assign reg_vld = vld && (sel == SEL_REG);

  ////////////////////////////////////////
  // response select
  ////////////////////////////////////////

  // select of every transfer, unmapped ones included
  tcb_dly #(
    .payload_t (sel_t)
  ) u_dly_sel (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .in_vld  (vld),
    .in_dat  (sel),
    .out_vld (rsp),
    .out_dat (dly_sel)
  );

  always_comb begin
    case (dly_sel)
      SEL_MEM: begin
        rdt = mem_rdt;
        err = mem_err;
      end
      SEL_REG: begin
        rdt = reg_rdt;
        err = reg_err;
      end
      // nothing answered this address
      default: begin
        rdt = '0;
        err = 1'b1;
      end
    endcase
  end

endmodule

// ==== source/tcb_sub_top.sv ====
/* TCB subsystem top: one manager port routed by the decoder to the data
   memory or the register block */

`timescale 1ns/1ns

module tcb_sub_top (
  input  logic          tcb,
  input  logic          arst_n,
  // request
  input  logic          vld,
  input  logic          wen,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::dat_t wdt,
  // response
  output logic          rsp,
  output tcb_pkg::dat_t rdt,
  output logic          err
);

  import tcb_pkg::*;

  logic mem_vld;
  logic reg_vld;
  dat_t mem_rdt;
  dat_t reg_rdt;
  logic mem_err;
  logic reg_err;
  // subordinate response strobes, aligned with rsp of their own transfers
  logic mem_rsp;
  logic reg_rsp;

  tcb_dec u_dec (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .vld     (vld),
    .adr     (adr),
    .mem_vld (mem_vld),
    .reg_vld (reg_vld),
    .mem_rdt (mem_rdt),
    .mem_err (mem_err),
    .reg_rdt (reg_rdt),
    .reg_err (reg_err),
    .rsp     (rsp),
    .rdt     (rdt),
    .err     (err)
  );

  // wen, adr, ben and wdt fan out to both targets unchanged
  tcb_mem u_mem (
    .tcb    (tcb),
    .arst_n (arst_n),
    .vld    (mem_vld),
    .wen    (wen),
    .adr    (adr),
    .ben    (ben),
    .wdt    (wdt),
    .rsp    (mem_rsp),
    .rdt    (mem_rdt),
    .err    (mem_err)
  );

  tcb_regs u_regs (
    .tcb    (tcb),
    .arst_n (arst_n),
    .vld    (reg_vld),
    .wen    (wen),
    .adr    (adr),
    .ben    (ben),
    .wdt    (wdt),
    .rsp    (reg_rsp),
    .rdt    (reg_rdt),
    .err    (reg_err)
  );

endmodule

// ==== bench/tcb_sub_props.sv ====
/* timing properties of the TCB subsystem top, bound to every instance
   of the top level */

`timescale 1ns/1ns

module tcb_sub_props (
  input  logic          tcb,
  input  logic          arst_n,
  input  logic          vld,
  input  logic          rsp,
  input  tcb_pkg::dat_t rdt,
  input  logic          err,
  // subordinate strobes inside the top level
  input  logic          mem_rsp,
  input  logic          reg_rsp
);

  import tcb_pkg::*;

  // every transfer is answered exactly DLY edges later
  rsp_after_vld: assert property (
    @(posedge tcb) disable iff (!arst_n) vld |-> ##DLY rsp
  ) else $error("rsp missing DLY cycles after a transfer");

  // an idle cycle gives no response DLY edges later
  no_rsp_after_idle: assert property (
    @(posedge tcb) disable iff (!arst_n) !vld |-> ##DLY !rsp
  ) else $error("rsp without a transfer DLY cycles earlier");

  rsp_low_in_reset: assert property (
    @(posedge tcb) !arst_n |-> !rsp
  ) else $error("rsp high during reset");

  // response payload is defined whenever it is strobed
  rsp_known: assert property (
    @(posedge tcb) disable iff (!arst_n) rsp |-> !$isunknown({rdt, err})
  ) else $error("rdt or err unknown while rsp is high");

  // a target answers only together with the top, never both at once
  sub_rsp_aligned: assert property (
    @(posedge tcb) disable iff (!arst_n)
      (mem_rsp || reg_rsp) |-> (rsp && !(mem_rsp && reg_rsp))
  ) else $error("subordinate rsp not aligned with the top rsp");

endmodule

bind tcb_sub_top tcb_sub_props u_props (.*);

// ==== bench/tcb_sub_tb.sv ====
/* testbench for the TCB subsystem: LCG driven transfers to memory, registers
   and unmapped space, checked in order against a reference model */

`timescale 1ns/1ns

module tcb_sub_tb;

  import tcb_pkg::*;

  localparam int unsigned N_RANDOM = 2000;

  // one expected response, tagged with the edge it is sampled at
  typedef struct {
    int unsigned due;
    dat_t        rdt;
    logic        err;
  } exp_t;

  logic tcb;
  logic arst_n;
  logic vld;
  logic wen;
  adr_t adr;
  ben_t ben;
  dat_t wdt;
  logic rsp;
  dat_t rdt;
  logic err;

  logic [31:0] lcg_state;
  int unsigned cyc;
  exp_t        exp_q[$];
  // reference model state
  dat_t        mem_m [MEM_WORDS];
  dat_t        scratch_m;
  dat_t        wcnt_m;

  tcb_sub_top DUT (
    .tcb    (tcb),
    .arst_n (arst_n),
    .vld    (vld),
    .wen    (wen),
    .adr    (adr),
    .ben    (ben),
    .wdt    (wdt),
    .rsp    (rsp),
    .rdt    (rdt),
    .err    (err)
  );

  always #20 tcb = ~tcb;

  // edges seen so far
  always @(posedge tcb) begin
    cyc <= cyc + 1;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic dat_t merge_bytes(dat_t old, dat_t upd, ben_t b);
    dat_t res;
    res = old;
    for (int i = 0; i < BEW; i++) begin
      if (b[i]) begin
        res[8*i +: 8] = upd[8*i +: 8];
      end
    end
    return res;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_dat(input string name, input dat_t got, input dat_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // applies one transfer to the model, returns the expected response
  task automatic model_access(input logic w, input adr_t a, input ben_t b, input dat_t d,
                              output dat_t e_rdt, output logic e_err);
    int unsigned word;
    e_rdt = '0;
    e_err = 1'b0;
    if (a >= MEM_BASE && a < MEM_BASE + MEM_WORDS * 4) begin
      word = (a - MEM_BASE) / 4;
      if (w) begin
        mem_m[word] = merge_bytes(mem_m[word], d, b);
      end else begin
        e_rdt = mem_m[word];
      end
    end else if (a >= REG_BASE && a < REG_BASE + REG_BYTES) begin
      word = (a - REG_BASE) / 4;
      // scratch, id, write count, then the unused slot
      if (word == 0 && w) begin
        scratch_m = merge_bytes(scratch_m, d, b);
        wcnt_m = wcnt_m + 1;
      end else if (word == 0) begin
        e_rdt = scratch_m;
      end else if (word == 1 && !w) begin
        e_rdt = REG_ID_VALUE;
      end else if (word == 2 && !w) begin
        e_rdt = wcnt_m;
      end else begin
        e_err = 1'b1;
      end
    end else begin
      e_err = 1'b1;
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic issue(input logic w, input adr_t a, input ben_t b, input dat_t d);
    exp_t e;
    dat_t e_rdt;
    logic e_err;
    @(posedge tcb);
    model_access(w, a, b, d, e_rdt, e_err);
    e.rdt = e_rdt;
    e.err = e_err;
    // DUT samples on the next edge, answer follows DLY edges later
    e.due = cyc + 2 + DLY;
    exp_q.push_back(e);
    vld <= 1'b1;
    wen <= w;
    adr <= a;
    ben <= b;
    wdt <= d;
  endtask

  task automatic idle();
    @(posedge tcb);
    vld <= 1'b0;
  endtask

  // address class from the low bits: memory, register, unused, unmapped
  task automatic random_transfer();
    logic [31:0] r;
    adr_t        a;
    r = next_rand();
    case (r[1:0])
      2'd0: a = MEM_BASE + adr_t'({r[15:8], r[17:16]});
      2'd1: a = REG_BASE + adr_t'((r[9:8] % 3) * 4 + r[17:16]);
      2'd2: a = REG_BASE + adr_t'(12 + r[17:16]);
      // bit 13 keeps it clear of both windows
      default: a = r[31:16] | 16'h2000;
    endcase
    if (r[20:18] == 3'd0) begin
      idle();
    end
    issue(r[2], a, r[7:4], next_rand());
  endtask

  ////////////////////////////////////////
  // response checker
  ////////////////////////////////////////

  // outputs settle well before the falling edge
  always @(negedge tcb) begin
    exp_t e;
    if ($isunknown(rsp)) begin
      abort_run("rsp is unknown");
    end else if (rsp) begin
      if (exp_q.size() == 0) begin
        abort_run("response arrived with no transfer outstanding");
      end else if (exp_q[0].due != cyc + 1) begin
        abort_run($sformatf("response at edge %0d but expected at edge %0d",
                            cyc + 1, exp_q[0].due));
      end else begin
        e = exp_q.pop_front();
        check_dat("rdt", rdt, e.rdt);
        check_err("err", err, e.err);
      end
    end else if (exp_q.size() > 0 && exp_q[0].due <= cyc + 1) begin
      abort_run("expected response did not arrive");
    end
  end

  initial begin
    tcb = 1'b0;
    arst_n = 1'b1;
    vld = 1'b0;
    wen = 1'b0;
    adr = '0;
    ben = '0;
    wdt = '0;
    cyc = 0;
    lcg_state = 32'he526_4fa3;
    scratch_m = '0;
    wcnt_m = '0;
    // reset edge lands before the first clock edge
    #5 arst_n = 1'b0;
    repeat (10) @(posedge tcb);
    arst_n <= 1'b1;
    // quiet after reset, rsp must stay low
    repeat (4) idle();
    // fill every memory word so later reads are defined
    for (int i = 0; i < MEM_WORDS; i++) begin
      issue(1'b1, MEM_BASE + adr_t'(i * 4), 4'hf, next_rand());
    end
    // directed register and unmapped accesses
    issue(1'b1, REG_BASE, 4'b0101, 32'h1122_3344);
    issue(1'b0, REG_BASE, 4'hf, '0);
    issue(1'b0, REG_BASE + adr_t'(4), 4'hf, '0);
    issue(1'b1, REG_BASE + adr_t'(4), 4'hf, 32'hdead_beef);
    issue(1'b1, REG_BASE + adr_t'(8), 4'hf, 32'h0000_00ff);
    issue(1'b0, REG_BASE + adr_t'(8), 4'hf, '0);
    issue(1'b0, REG_BASE + adr_t'(12), 4'hf, '0);
    issue(1'b0, 16'h8000, 4'hf, '0);
    issue(1'b0, REG_BASE + adr_t'(4), 4'hf, '0);
    repeat (N_RANDOM) random_transfer();
    idle();
    // drain outstanding responses
    for (int i = 0; i < 10 * DLY && exp_q.size() > 0; i++) begin
      @(posedge tcb);
    end
    if (exp_q.size() > 0) begin
      abort_run("timeout while waiting for outstanding responses");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

// ==== tcb_sub.f ====
source/tcb_pkg.sv
source/tcb_dly.sv
source/tcb_mem.sv
source/tcb_regs.sv
source/tcb_dec.sv
source/tcb_sub_top.sv
bench/tcb_sub_props.sv
bench/tcb_sub_tb.sv
